// File: compile.f
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_slot_if.sv
hw/decode_stage.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipe_core_top.sv
tb/isa_ref_pkg.sv
tb/pipe_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := pipe_core_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/pipe_core_tb.sv
`include "cpu_consts.svh"

module pipe_core_tb import cpu_pkg::*, isa_ref_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int NPROG        = 20;
  localparam int PROG_LEN     = 40;                              // halt is the last one
  localparam int WATCH_CYCLES = NPROG * PROG_LEN * 4 + 200;

  logic       clk;
  logic       rst_n;
  logic       imem_we;
  imem_addr_t imem_addr;
  instr_t     imem_wdata;
  logic       run_req;
  logic       run_ack;
  logic       wb_valid;
  reg_idx_t   wb_reg;
  word_t      wb_data;
  logic       st_valid;
  dmem_addr_t st_addr;
  word_t      st_data;
  logic       idle_phase;  // core is between runs, so every output must stay low

  pipe_core_top UUT (
    .clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .run_req(run_req), .run_ack(run_ack),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // search for a base and offset that land on a word stored earlier, so a load never reads junk
  function automatic logic pick_load(output reg_idx_t base, output logic [4:0] imm);
    word_t       sum;
    int unsigned start;
    start = $urandom;
    base  = '0;
    imm   = '0;
    for (int unsigned k = 0; k < 128; k++) begin
      base = reg_idx_t'(((start + k) / 32) % 4);
      imm  = 5'(start + k);
      sum  = regs[base] + {{11{imm[4]}}, imm};
      if (mem_set[sum[7:0]]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // registers come from r0..r3 so that back-to-back dependencies are common
  function automatic instr_t random_instr();
    int unsigned kind;
    reg_idx_t    ra;
    reg_idx_t    rb;
    reg_idx_t    rc;
    reg_idx_t    lb;
    logic [4:0]  imm;
    logic [4:0]  li;
    kind = $urandom_range(9);
    ra   = reg_idx_t'($urandom_range(3));
    rb   = reg_idx_t'($urandom_range(3));
    rc   = reg_idx_t'($urandom_range(3));
    imm  = 5'($urandom);
    case (kind)
      0: return {`OP_NOP, 11'd0};
      1: return {`OP_ADDI, ra, rb, imm};
      2, 3: begin
        if (pick_load(lb, li)) return {`OP_LD, lb, rb, li};
        return {`OP_ST, ra, rb, imm};  // nothing loadable yet, store something instead
      end
      4: return {`OP_ST, ra, rb, imm};
      5: return {`OP_STU, ra, rb, imm};
      6: return {`OP_LBI, ra, 8'($urandom)};
      7: return {`OP_SLBI, ra, 8'($urandom)};
      default: return {`OP_RTYPE, ra, rb, rc, 2'($urandom)};
    endcase
  endfunction

  task automatic load_program(input instr_t prog[$]);
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= imem_addr_t'(i);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  // raise run_req, wait for run_ack, then drop run_req and see run_ack fall a cycle later
  task automatic run_program(input int num);
    @(posedge clk);
    run_req    <= 1'b1;
    idle_phase = 1'b0;
    do @(negedge clk); while (!run_ack);
    assert (wb_q.size() == 0 && st_q.size() == 0)
      else stop_on_error($sformatf(
        "program %0d acknowledged with %0d writebacks and %0d stores missing",
        num, wb_q.size(), st_q.size()));
    @(posedge clk);
    run_req <= 1'b0;
    @(negedge clk);
    assert (run_ack) else stop_on_error("run_ack dropped before the fall of run_req was seen");
    @(negedge clk);
    assert (!run_ack) else stop_on_error("run_ack still high one cycle after run_req fell");
    idle_phase = 1'b1;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    wb_ev_t ew;
    st_ev_t es;
    if (rst_n && idle_phase) begin
      assert (!run_ack && !wb_valid && !st_valid)
        else stop_on_error("core output active while no run was requested");
    end
    if (rst_n && wb_valid) begin
      assert (wb_q.size() != 0) else stop_on_error("register write seen with none expected");
      ew = wb_q.pop_front();
      assert (wb_reg == ew.r && wb_data == ew.d)
        else stop_on_error($sformatf("Mismatch at %0t: writeback r%0d=%h, expected r%0d=%h",
                                     $time, wb_reg, wb_data, ew.r, ew.d));
    end
    if (rst_n && st_valid) begin
      assert (st_q.size() != 0) else stop_on_error("store seen with none expected");
      es = st_q.pop_front();
      assert (st_addr == es.a && st_data == es.d)
        else stop_on_error($sformatf("Mismatch at %0t: store [%h]=%h, expected [%h]=%h",
                                     $time, st_addr, st_data, es.a, es.d));
    end
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("timeout after %0d cycles without finishing the programs",
                            WATCH_CYCLES));
  end

  initial begin
    instr_t prog [$];
    instr_t ins;
    void'($urandom(32'h20fc_1d7c));
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    run_req    = 1'b0;
    idle_phase = 1'b1;
    reset_model();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int p = 0; p < NPROG; p++) begin
      prog = {};
      for (int i = 0; i < PROG_LEN - 1; i++) begin
        ins = random_instr();  // model steps as it goes, so loads see the stores before them
        prog.push_back(ins);
        step(ins);
      end
      prog.push_back({`OP_HALT, 11'd0});
      load_program(prog);
      run_program(p);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: tb/isa_ref_pkg.sv
`include "cpu_consts.svh"

// instruction-level model of the core, stepped one instruction at a time
package isa_ref_pkg;
  import cpu_pkg::*;

  typedef struct packed {
    reg_idx_t r;
    word_t    d;
  } wb_ev_t;

  typedef struct packed {
    dmem_addr_t a;
    word_t      d;
  } st_ev_t;

  word_t  regs    [`CPU_NREG];        // architectural registers, kept from one program to the next
  word_t  mem     [`CPU_DMEM_DEPTH];
  logic   mem_set [`CPU_DMEM_DEPTH];  // word has been stored at least once
  wb_ev_t wb_q [$];                   // expected register writes in program order
  st_ev_t st_q [$];                   // expected stores in program order

  // registers come out of reset as zero, the data memory holds nothing known
  function automatic void reset_model();
    for (int i = 0; i < `CPU_NREG; i++) regs[i] = '0;
    for (int i = 0; i < `CPU_DMEM_DEPTH; i++) mem_set[i] = 1'b0;
    wb_q.delete();
    st_q.delete();
  endfunction

  function automatic void write_reg(reg_idx_t r, word_t d);
    regs[r] = d;
    wb_q.push_back('{r: r, d: d});
  endfunction

  function automatic void store_word(dmem_addr_t a, word_t d);
    mem[a]     = d;
    mem_set[a] = 1'b1;
    st_q.push_back('{a: a, d: d});
  endfunction

  // one instruction of the isa, all sums wrap at 16 bits
  function automatic void step(instr_t ins);
    logic [4:0] op;
    reg_idx_t   rs;
    reg_idx_t   rb;
    word_t      a;
    word_t      sum;
    word_t      r;
    op  = ins[15:11];
    rs  = ins[10:8];
    rb  = ins[7:5];                            // rt, the i-format rd, or the store data register
    a   = regs[rs];
    sum = a + {{11{ins[4]}}, ins[4:0]};        // addi result and memory address
    case (op)
      `OP_RTYPE: begin
        case (ins[1:0])
          `FN_ADD: r = a + regs[rb];
          `FN_SUB: r = a - regs[rb];
          `FN_XOR: r = a ^ regs[rb];
          default: r = a & ~regs[rb];
        endcase
        write_reg(ins[4:2], r);
      end
      `OP_ADDI: write_reg(rb, sum);
      `OP_LD:   write_reg(rb, mem[sum[7:0]]);
      `OP_ST:   store_word(sum[7:0], regs[rb]);
      `OP_STU: begin
        store_word(sum[7:0], regs[rb]);        // data is read before rs takes the sum
        write_reg(rs, sum);
      end
      `OP_LBI:  write_reg(rs, {{8{ins[7]}}, ins[7:0]});
      `OP_SLBI: write_reg(rs, {a[7:0], ins[7:0]});
      default: ;                               // nop and halt change nothing
    endcase
  endfunction

endpackage

// File: hw/pipe_core_top.sv
`include "cpu_consts.svh"

module pipe_core_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  instr_t     imem_wdata,
  input  logic       run_req,
  output logic       run_ack,
  output logic       wb_valid,
  output reg_idx_t   wb_reg,
  output word_t      wb_data,
  output logic       st_valid,
  output dmem_addr_t st_addr,
  output word_t      st_data
);

  core_state_t state;
  instr_t      imem [`CPU_IMEM_DEPTH];
  imem_addr_t  pc;
  instr_t      instr;
  instr_t      d_instr;
  instr_t      dx_instr;
  word_t       raw_rs;
  word_t       raw_rt;
  word_t       fwd_rs;
  word_t       fwd_rt;
  word_t       dx_a;
  word_t       dx_b;
  logic        dx_valid;
  logic        halt_done;
  logic        run;

  pipe_slot_if e_slot ();
  pipe_slot_if m_slot ();

  // program loading only while the core sits idle
  always_ff @(posedge clk) begin
    if (imem_we && state == IDLE) imem[imem_addr] <= imem_wdata;
  end

  assign instr = imem[pc];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (run_req)   state <= RUN;
        RUN:     if (halt_done) state <= DONE;  // halt has reached m
        DONE:    if (!run_req)  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign run     = state == RUN;
  assign run_ack = state == DONE;  // one cycle after halt in m, drops one cycle after run_req

  decode_stage u_decode (
    .clk, .rst_n, .run, .instr, .pc, .m(m_slot.consumer), .fwd_rs, .fwd_rt,
    .raw_rs, .raw_rt, .d_instr, .dx_instr, .dx_a, .dx_b, .dx_valid
  );

  forward_unit u_forward (
    .d_instr, .raw_rs, .raw_rt, .e(e_slot.consumer), .m(m_slot.consumer), .fwd_rs, .fwd_rt
  );

  execute_stage u_execute (
    .clk, .rst_n, .dx_instr, .dx_a, .dx_b, .dx_valid, .e(e_slot.producer)
  );

  memory_stage u_memory (
    .clk, .rst_n, .e(e_slot.consumer), .m(m_slot.producer), .wb_valid, .wb_reg, .wb_data,
    .st_valid, .st_addr, .st_data, .halt_done
  );

endmodule

// File: hw/memory_stage.sv
`include "cpu_consts.svh"

module memory_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  pipe_slot_if.consumer e,
  pipe_slot_if.producer m,
  output logic       wb_valid,
  output reg_idx_t   wb_reg,
  output word_t      wb_data,
  output logic       st_valid,
  output dmem_addr_t st_addr,
  output word_t      st_data,
  output logic       halt_done
);

  word_t      dmem [`CPU_DMEM_DEPTH];
  dmem_addr_t e_addr;
  opcode_t    e_op;
  opcode_t    m_op;
  logic       e_store;

  assign e_addr  = e.result[7:0];  // only the low byte addresses memory
  assign e_op    = e.instr[15:11];
  assign m_op    = m.instr[15:11];
  assign e_store = e.valid && (e_op == `OP_ST || e_op == `OP_STU);

  always_ff @(posedge clk) begin
    if (e_store) dmem[e_addr] <= e.load_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) m.valid <= 1'b0;
    else        m.valid <= e.valid;
  end

  // write controls already carry e.valid
  always_ff @(posedge clk) begin
    m.instr     <= e.instr;
    m.rd        <= e.rd;
    m.rs        <= e.rs;
    m.reg_write <= e.reg_write;
    m.write_rs  <= e.write_rs;
    m.mem_read  <= e.mem_read;
    m.result    <= e.result;
    m.load_data <= e.mem_read ? dmem[e_addr] : e.load_data;  // stores keep their data
  end

  // writeback trace, stu sends the address sum back to rs
  assign wb_valid = m.valid && (m.reg_write || m.write_rs);
  assign wb_reg   = m.write_rs ? m.rs : m.rd;
  assign wb_data  = m.mem_read ? m.load_data : m.result;

  // store trace shows the write made during the previous cycle
  assign st_valid = m.valid && (m_op == `OP_ST || m_op == `OP_STU);
  assign st_addr  = m.result[7:0];
  assign st_data  = m.load_data;

  assign halt_done = m.valid && m_op == `OP_HALT;

endmodule

// File: hw/execute_stage.sv
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  instr_t dx_instr,
  input  word_t  dx_a,       // rs operand
  input  word_t  dx_b,       // rt or store data
  input  logic   dx_valid,
  pipe_slot_if.producer e
);

  opcode_t    op;
  logic [1:0] fn;
  logic       rtype;
  word_t      imm5;
  word_t      imm8;
  word_t      alu;

  assign op    = dx_instr[15:11];
  assign fn    = dx_instr[1:0];
  assign rtype = op == `OP_RTYPE;
  assign imm5  = {{11{dx_instr[4]}}, dx_instr[4:0]};
  assign imm8  = {{8{dx_instr[7]}}, dx_instr[7:0]};

  always_comb begin
    case (op)
      `OP_RTYPE: begin
        case (fn)
          `FN_ADD: alu = dx_a + dx_b;
          `FN_SUB: alu = dx_a - dx_b;   // rs minus rt
          `FN_XOR: alu = dx_a ^ dx_b;
          default: alu = dx_a & ~dx_b;  // andn
        endcase
      end
      `OP_ADDI, `OP_LD, `OP_ST, `OP_STU: alu = dx_a + imm5;  // also the memory address
      `OP_LBI:  alu = imm8;
      `OP_SLBI: alu = {dx_a[7:0], dx_instr[7:0]};
      default:  alu = dx_a;
    endcase
  end

  // the e slot shows the instruction held in the decode-to-execute register
  assign e.valid     = dx_valid;
  assign e.instr     = dx_instr;
  assign e.rd        = rtype ? dx_instr[4:2] : dx_instr[7:5];
  assign e.rs        = dx_instr[10:8];
  assign e.reg_write = dx_valid && (rtype || op == `OP_ADDI || op == `OP_LD);
  assign e.write_rs  = dx_valid && (op == `OP_STU || op == `OP_LBI || op == `OP_SLBI);
  assign e.mem_read  = dx_valid && op == `OP_LD;
  assign e.result    = alu;
  assign e.load_data = dx_b;  // store data rides along to memory

  // a load in execute is always followed by a bubble or an instruction that skips its target
  ld_use_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (e.valid && e.mem_read) |=> !(dx_valid &&
      ((uses_rs(op) && dx_instr[10:8] == $past(e.rd)) ||
       (uses_b(op) && dx_instr[7:5] == $past(e.rd)))));

endmodule

// File: hw/forward_unit.sv
`include "cpu_consts.svh"

module forward_unit import cpu_pkg::*; (
  input  instr_t d_instr,
  input  word_t  raw_rs,
  input  word_t  raw_rt,
  pipe_slot_if.consumer e,
  pipe_slot_if.consumer m,
  output word_t  fwd_rs,
  output word_t  fwd_rt
);

  opcode_t  d_op;
  reg_idx_t src_a;
  reg_idx_t src_b;
  logic     use_a;
  logic     use_b;
  logic     e_ok;     // e slot may forward
  logic     e_hit_a;
  logic     e_hit_b;
  logic     m_hit_a;
  logic     m_hit_b;
  word_t    m_val;

  // slot is live and writes register r through rd or rs
  function automatic logic writes_reg(logic v, logic wr_rd, reg_idx_t rd,
                                      logic wr_rs, reg_idx_t rs, reg_idx_t r);
    return v && ((wr_rd && rd == r) || (wr_rs && rs == r));
  endfunction

  assign d_op  = d_instr[15:11];
  assign src_a = d_instr[10:8];
  // st and stu keep the store data register where r-format keeps rt
  // so the second operand path also carries the store data
  assign src_b = d_instr[7:5];
  assign use_a = uses_rs(d_op);
  assign use_b = uses_b(d_op);

  // a load in e only has its address, decode stalls on that case instead
  assign e_ok = e.valid && !e.mem_read;

  assign e_hit_a = use_a && writes_reg(e_ok, e.reg_write, e.rd, e.write_rs, e.rs, src_a);
  assign e_hit_b = use_b && writes_reg(e_ok, e.reg_write, e.rd, e.write_rs, e.rs, src_b);
  assign m_hit_a = use_a && writes_reg(m.valid, m.reg_write, m.rd, m.write_rs, m.rs, src_a);
  assign m_hit_b = use_b && writes_reg(m.valid, m.reg_write, m.rd, m.write_rs, m.rs, src_b);

  assign m_val = m.mem_read ? m.load_data : m.result;  // loaded word or alu result

  // e is the newer writer and wins over m
  assign fwd_rs = e_hit_a ? e.result : (m_hit_a ? m_val : raw_rs);
  assign fwd_rt = e_hit_b ? e.result : (m_hit_b ? m_val : raw_rt);

  // mem_read is decoded in execute, the loaded word must only come from a real ld
  always_comb begin
    load_pick_ok: assert final (!((m_hit_a || m_hit_b) && m.mem_read) ||
                                m.instr[15:11] == `OP_LD);
  end

endmodule

// File: hw/decode_stage.sv
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  instr_t     instr,     // imem word at pc
  output imem_addr_t pc,
  pipe_slot_if.consumer m,
  input  word_t      fwd_rs,
  input  word_t      fwd_rt,
  output word_t      raw_rs,
  output word_t      raw_rt,
  output instr_t     d_instr,
  output instr_t     dx_instr,
  output word_t      dx_a,
  output word_t      dx_b,
  output logic       dx_valid
);

  word_t    rf [`CPU_NREG];
  logic     halted;            // halt has been fetched this run
  logic     d_valid;
  logic     stall;
  opcode_t  d_op;
  opcode_t  dx_op;
  reg_idx_t src_a;
  reg_idx_t src_b;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  assign d_instr = instr;  // imem is read combinationally so fetch and decode share a cycle
  assign d_op    = d_instr[15:11];
  assign src_a   = d_instr[10:8];
  assign src_b   = d_instr[7:5];  // rt or store data register
  assign dx_op   = dx_instr[15:11];
  assign d_valid = run && !halted;

  // writeback from the m slot, a slot writes either rd or rs but never both
  assign wr_en   = m.valid && (m.reg_write || m.write_rs);
  assign wr_idx  = m.write_rs ? m.rs : m.rd;
  assign wr_data = m.mem_read ? m.load_data : m.result;

  // same-cycle write shows through to the read
  assign raw_rs = (wr_en && wr_idx == src_a) ? wr_data : rf[src_a];
  assign raw_rt = (wr_en && wr_idx == src_b) ? wr_data : rf[src_b];

  // ld in execute has no data yet, so hold the reader back one cycle
  // ld keeps its target in instr[7:5]
  assign stall = d_valid && dx_valid && dx_op == `OP_LD &&
                 ((uses_rs(d_op) && src_a == dx_instr[7:5]) ||
                  (uses_b(d_op) && src_b == dx_instr[7:5]));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREG; i++) begin
        rf[i] <= '0;
      end
    end else if (wr_en) begin
      rf[wr_idx] <= wr_data;  // lands at the end of the m cycle
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= '0;
      halted   <= 1'b0;
      dx_valid <= 1'b0;
    end else if (!run) begin
      pc       <= '0;    // next run starts from address zero
      halted   <= 1'b0;
      dx_valid <= 1'b0;
    end else begin
      if (d_valid && !stall) begin
        if (d_op == `OP_HALT) halted <= 1'b1;  // pc freezes on halt
        else                  pc     <= pc + 8'd1;
      end
      dx_valid <= d_valid && !stall;  // a stall sends a bubble
    end
  end

  // payload follows dx_valid
  always_ff @(posedge clk) begin
    dx_instr <= d_instr;
    dx_a     <= fwd_rs;
    dx_b     <= fwd_rt;
  end

  // the bubble clears the hazard, so a second stall cycle points at a broken pipe
  single_stall: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall);

endmodule

// File: hw/pipe_slot_if.sv
// one pipeline slot as seen by the forwarding logic
interface pipe_slot_if import cpu_pkg::*; ();

  logic     valid;      // slot holds a live instruction
  instr_t   instr;
  reg_idx_t rd;         // destination for r-format, addi and ld
  reg_idx_t rs;
  logic     reg_write;  // slot writes rd
  logic     write_rs;   // slot writes rs, only stu lbi and slbi do
  logic     mem_read;
  word_t    result;     // alu result or memory address
  word_t    load_data;  // loaded word in the m slot, store data in the e slot

  modport producer (
    output valid, instr, rd, rs, reg_write, write_rs, mem_read, result, load_data
  );

  modport consumer (
    input valid, instr, rd, rs, reg_write, write_rs, mem_read, result, load_data
  );

endinterface

// File: hw/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [15:0] word_t;       // data word, all arithmetic wraps here
  typedef logic [15:0] instr_t;
  typedef logic [2:0]  reg_idx_t;    // eight architectural registers
  typedef logic [4:0]  opcode_t;
  typedef logic [7:0]  imem_addr_t;
  typedef logic [7:0]  dmem_addr_t;

  // run handshake of the core
  typedef enum logic [1:0] {
    IDLE,  // program may be loaded
    RUN,   // fetching until halt retires
    DONE   // run_ack high, waiting for run_req to drop
  } core_state_t;

  // true when the instruction reads rs in instr[10:8]
  function automatic logic uses_rs(opcode_t op);
    return !(op == `OP_NOP || op == `OP_HALT || op == `OP_LBI);
  endfunction

  // true when instr[7:5] is read as the second operand
  // this is rt for r-format and the store data register for st and stu
  function automatic logic uses_b(opcode_t op);
    return op == `OP_RTYPE || op == `OP_ST || op == `OP_STU;
  endfunction

endpackage

// File: hw/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_NREG        8    // r0 to r7
`define CPU_IMEM_DEPTH  256
`define CPU_DMEM_DEPTH  256

// opcodes sit in instr[15:11]
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_ADDI   5'b01000
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_SLBI   5'b10010
`define OP_STU    5'b10011
`define OP_LBI    5'b11000
`define OP_RTYPE  5'b11011

// r-format function field in instr[1:0]
`define FN_ADD    2'b00
`define FN_SUB    2'b01
`define FN_XOR    2'b10
`define FN_ANDN   2'b11

`endif
